/* hdl/pcGenerator.sv */
/*
 * Fetch PC generator
 *   loads the recovered PC, else steps one instruction
 *   per enabled commit cycle
 */

`timescale 1ns/10ps

module pcGenerator import recoveryPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  pipelinePhase         phase,
    input  logic                 fetchEnable,
    input  logic                 recoverPc,
    input  logic [addrWidth-1:0] recoveredPc,
    output logic [addrWidth-1:0] fetchPc
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchPc <= '0;
        end else if (recoverPc) begin
            fetchPc <= recoveredPc;
        end else if (phase == phaseCommit && fetchEnable) begin
            fetchPc <= fetchPc + addrWidth'(insnByteWidth);
        end
        // holds during recover-1
    end

endmodule

/* hdl/recoveryIf.sv */
/*
 * Recovery interface between the recovery manager and the
 * rename-map walker: phase, walk start pulse, flush range,
 * and the walker busy level.
 */

`timescale 1ns/10ps

interface recoveryIf import recoveryPkg::*; #(
    parameter int alIndexBits = alIndexWidth
);

    pipelinePhase           phase;
    logic                   startWalk;
    logic [alIndexBits-1:0] flushHead;
    logic [alIndexBits-1:0] flushTail;
    logic                   walkBusy;

    modport manager (
        output phase, startWalk, flushHead, flushTail,
        input  walkBusy
    );

    modport walker (
        input  startWalk, flushHead, flushTail,
        output walkBusy
    );

endinterface

/* hdl/recoveryManager.sv */
/*
 * Recovery manager
 *   commit / recover-0 / recover-1 phase machine
 *   registered exception request from commit or register-write stage
 *   flush range and recovered PC selection
 *   protocol assertions
 */

`timescale 1ns/10ps

module recoveryManager import recoveryPkg::*; #(
    parameter int alIndexBits = alIndexWidth
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   excCommit,
    input  logic                   excRw,
    input  refetchType             refetchTypeCommit,
    input  refetchType             refetchTypeRw,
    input  logic [addrWidth-1:0]   pcCommit,
    input  logic [addrWidth-1:0]   pcRw,
    input  logic [addrWidth-1:0]   faultAddr,
    input  excCause                causeCommit,
    input  logic [alIndexBits-1:0] excOpPtr,
    input  logic [alIndexBits-1:0] flushTailPtr,
    input  logic [addrWidth-1:0]   trapTarget,
    output logic                   trapTrigger,
    output logic [addrWidth-1:0]   trapExcPc,
    output excCause                trapCauseOut,
    output logic [addrWidth-1:0]   trapFaultAddr,
    output logic                   recoverPc,
    output logic [addrWidth-1:0]   recoveredPc,
    output logic                   recoveryFromRw,
    output logic                   unableToStartRecovery,
    recoveryIf.manager             rec
);

    pipelinePhase           phaseQ;
    pipelinePhase           phaseD;
    logic                   fromCommitQ;
    refetchType             typeQ;
    logic [addrWidth-1:0]   pcCommitQ;
    logic [addrWidth-1:0]   pcRwQ;
    excCause                causeQ;
    logic [addrWidth-1:0]   faultAddrQ;
    logic [alIndexBits-1:0] headQ;
    logic [alIndexBits-1:0] tailQ;

    logic                   accept;
    refetchType             selType;
    logic [addrWidth-1:0]   regPc;

    // requests only enter in commit, commit stage wins a tie
    assign accept  = (phaseQ == phaseCommit) && (excCommit || excRw);
    assign selType = excCommit ? refetchTypeCommit : refetchTypeRw;

    always_comb begin
        phaseD = phaseQ;
        case (phaseQ)
            phaseCommit:   if (accept) phaseD = phaseRecover0;
            phaseRecover0: phaseD = phaseRecover1;
            phaseRecover1: if (!rec.walkBusy) phaseD = phaseCommit;
            default:       phaseD = phaseCommit;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phaseQ         <= phaseCommit;
            fromCommitQ    <= 1'b0;
            recoveryFromRw <= 1'b0;
            typeQ          <= refetchThisPc;
            headQ          <= '0;
            tailQ          <= '0;
        end else begin
            phaseQ <= phaseD;
            if (accept) begin
                fromCommitQ    <= excCommit;
                recoveryFromRw <= excRw;
                typeQ          <= selType;
                headQ          <= isThisPc(selType) ? excOpPtr : excOpPtr + 1'b1;
                tailQ          <= flushTailPtr;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            pcCommitQ  <= pcCommit;
            pcRwQ      <= pcRw;
            causeQ     <= causeCommit;
            faultAddrQ <= faultAddr;
        end
    end

    assign regPc = fromCommitQ ? pcCommitQ : pcRwQ;

    always_comb begin
        case (typeQ)
            refetchThisPcToCsr,
            refetchNextPcToCsr: recoveredPc = trapTarget;
            refetchNextPc:      recoveredPc = regPc + addrWidth'(insnByteWidth);
            default:            recoveredPc = regPc;
        endcase
    end

    // everything downstream acts in recover-0
    assign recoverPc     = (phaseQ == phaseRecover0);
    assign trapTrigger   = (phaseQ == phaseRecover0) && isToCsr(typeQ);
    assign trapExcPc     = pcCommitQ;
    assign trapCauseOut  = causeQ;
    assign trapFaultAddr = faultAddrQ;

    assign rec.phase     = phaseQ;
    assign rec.startWalk = (phaseQ == phaseRecover0);
    assign rec.flushHead = headQ;
    assign rec.flushTail = tailQ;

    assign unableToStartRecovery = (phaseQ != phaseCommit) || rec.walkBusy;

    // traps are raised at commit only
    rwNotToCsr: assert property (@(posedge clk) disable iff (!arstN)
        excRw && !excCommit |-> !isToCsr(refetchTypeRw));

    // a request is taken only when a recovery could start
    acceptWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
        accept |-> !unableToStartRecovery);

    // the walker starts only once a recovery is under way
    noBusyInCommit: assert property (@(posedge clk) disable iff (!arstN)
        $rose(rec.walkBusy) |-> phaseQ != phaseCommit);

endmodule

/* hdl/recoveryPkg.sv */
/*
 * Shared definitions for the recovery controller:
 *   address and active list widths, instruction size,
 *   pipeline phase and refetch type enums, trap cause type,
 *   and a helper that tells the trap refetch types apart.
 */

package recoveryPkg;

    // PC and data address width
    localparam int addrWidth = 32;

    // 16-entry active list, pointer wraps
    localparam int alIndexWidth = 4;

    // one instruction in bytes
    localparam int insnByteWidth = 4;

    typedef enum logic [1:0] {
        phaseCommit   = 2'd0,
        phaseRecover0 = 2'd1,
        phaseRecover1 = 2'd2
    } pipelinePhase;

    typedef enum logic [2:0] {
        refetchThisPc       = 3'd0,
        refetchNextPc       = 3'd1,
        refetchBranchTarget = 3'd2,
        refetchThisPcToCsr  = 3'd3,
        refetchNextPcToCsr  = 3'd4
    } refetchType;

    // trap cause code
    typedef logic [3:0] excCause;

    // true for the two types that go through the trap vector
    function automatic logic isToCsr(input refetchType kind);
        return (kind == refetchThisPcToCsr) || (kind == refetchNextPcToCsr);
    endfunction

    // flush starts at the excepting entry for these
    function automatic logic isThisPc(input refetchType kind);
        return (kind == refetchThisPc) || (kind == refetchThisPcToCsr);
    endfunction

endpackage

/* hdl/recoveryTop.sv */
/*
 * Recovery controller top level
 *   recovery interface, recovery manager, trap CSR,
 *   rename-map walker and fetch PC generator
 */

`timescale 1ns/10ps

module recoveryTop import recoveryPkg::*; #(
    parameter int alIndexBits = alIndexWidth
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   excCommit,
    input  logic                   excRw,
    input  refetchType             refetchTypeCommit,
    input  refetchType             refetchTypeRw,
    input  logic [addrWidth-1:0]   pcCommit,
    input  logic [addrWidth-1:0]   pcRw,
    input  excCause                causeCommit,
    input  logic [addrWidth-1:0]   faultAddr,
    input  logic [alIndexBits-1:0] excOpPtr,
    // detected flush range end from the active list
    input  logic [alIndexBits-1:0] detectedTailPtr,
    input  logic                   tvecWrite,
    input  logic [addrWidth-1:0]   tvecData,
    input  logic                   fetchEnable,
    output pipelinePhase           phase,
    output logic [addrWidth-1:0]   fetchPc,
    output logic [alIndexBits-1:0] flushHeadPtr,
    output logic [alIndexBits-1:0] flushTailPtr,
    output logic                   recoveryFromRw,
    output logic                   unableToStartRecovery,
    output logic [addrWidth-1:0]   trapPc,
    output excCause                trapCause,
    output logic [addrWidth-1:0]   trapValue
);

    logic                 trapTrigger;
    logic [addrWidth-1:0] trapExcPc;
    excCause              trapCauseOut;
    logic [addrWidth-1:0] trapFaultAddr;
    logic [addrWidth-1:0] trapTarget;
    logic                 recoverPc;
    logic [addrWidth-1:0] recoveredPc;

    recoveryIf #(.alIndexBits(alIndexBits)) u_recoveryIf ();

    recoveryManager #(.alIndexBits(alIndexBits)) u_recoveryManager (
        .clk(clk), .arstN(arstN),
        .excCommit(excCommit), .excRw(excRw),
        .refetchTypeCommit(refetchTypeCommit), .refetchTypeRw(refetchTypeRw),
        .pcCommit(pcCommit), .pcRw(pcRw), .faultAddr(faultAddr),
        .causeCommit(causeCommit),
        .excOpPtr(excOpPtr), .flushTailPtr(detectedTailPtr),
        .trapTarget(trapTarget),
        .trapTrigger(trapTrigger), .trapExcPc(trapExcPc),
        .trapCauseOut(trapCauseOut), .trapFaultAddr(trapFaultAddr),
        .recoverPc(recoverPc), .recoveredPc(recoveredPc),
        .recoveryFromRw(recoveryFromRw),
        .unableToStartRecovery(unableToStartRecovery),
        .rec(u_recoveryIf.manager)
    );

    trapCsr u_trapCsr (
        .clk(clk), .arstN(arstN),
        .tvecWrite(tvecWrite), .tvecData(tvecData),
        .trigger(trapTrigger), .excPc(trapExcPc),
        .cause(trapCauseOut), .faultAddr(trapFaultAddr),
        .trapTarget(trapTarget),
        .trapPc(trapPc), .trapCause(trapCause), .trapValue(trapValue)
    );

    rmtWalker #(.alIndexBits(alIndexBits)) u_rmtWalker (
        .clk(clk), .arstN(arstN),
        .rec(u_recoveryIf.walker)
    );

    pcGenerator u_pcGenerator (
        .clk(clk), .arstN(arstN),
        .phase(u_recoveryIf.phase), .fetchEnable(fetchEnable),
        .recoverPc(recoverPc), .recoveredPc(recoveredPc),
        .fetchPc(fetchPc)
    );

    assign phase        = u_recoveryIf.phase;
    assign flushHeadPtr = u_recoveryIf.flushHead;
    assign flushTailPtr = u_recoveryIf.flushTail;

endmodule

/* hdl/rmtWalker.sv */
/*
 * Rename-map walker
 *   loads the flush range length on startWalk
 *   visits one entry per cycle, busy while entries remain
 */

`timescale 1ns/10ps

module rmtWalker import recoveryPkg::*; #(
    parameter int alIndexBits = alIndexWidth
) (
    input  logic       clk,
    input  logic       arstN,
    recoveryIf.walker  rec
);

    logic [alIndexBits-1:0] rangeLen;
    logic [alIndexBits-1:0] walkCnt;
    logic [alIndexBits-1:0] walkCntD;

    // range length, wraps past the end of the list
    assign rangeLen = rec.flushTail - rec.flushHead;

    always_comb begin
        if (rec.startWalk) begin
            walkCntD = rangeLen;
        end else if (walkCnt != '0) begin
            walkCntD = walkCnt - 1'b1;
        end else begin
            walkCntD = '0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            walkCnt <= '0;
        end else begin
            walkCnt <= walkCntD;
        end
    end

    // busy while another entry is still to be restored,
    // so the manager can leave recover-1 right on the last visit
    assign rec.walkBusy = (walkCntD != '0);

    // a new walk only after the previous one has drained
    noStartWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
        rec.startWalk |-> walkCnt == '0);

endmodule

/* hdl/trapCsr.sv */
/*
 * Trap CSR block
 *   trap vector register with write port
 *   exception PC, cause and fault address capture on trigger
 *   aligned trap target output
 */

`timescale 1ns/10ps

module trapCsr import recoveryPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 tvecWrite,
    input  logic [addrWidth-1:0] tvecData,
    input  logic                 trigger,
    input  logic [addrWidth-1:0] excPc,
    input  excCause              cause,
    input  logic [addrWidth-1:0] faultAddr,
    output logic [addrWidth-1:0] trapTarget,
    output logic [addrWidth-1:0] trapPc,
    output excCause              trapCause,
    output logic [addrWidth-1:0] trapValue
);

    logic [addrWidth-1:0] tvecQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tvecQ <= '0;
        end else if (tvecWrite) begin
            tvecQ <= tvecData;
        end
    end

    // direct mode only, low bits are the mode field
    assign trapTarget = {tvecQ[addrWidth-1:2], 2'b00};

    // trap state, taken at the end of recover-0
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            trapPc    <= '0;
            trapCause <= '0;
            trapValue <= '0;
        end else if (trigger) begin
            trapPc    <= excPc;
            trapCause <= cause;
            trapValue <= faultAddr;
        end
    end

    // software must not move the vector while a trap is being taken
    noWriteOnTrap: assert property (@(posedge clk) disable iff (!arstN)
        !(tvecWrite && trigger));

endmodule

/* src.f */
hdl/recoveryPkg.sv
hdl/recoveryIf.sv
hdl/recoveryManager.sv
hdl/trapCsr.sv
hdl/rmtWalker.sv
hdl/pcGenerator.sv
hdl/recoveryTop.sv
tb/clockGen.sv
tb/recoveryTb.sv

/* tb/clockGen.sv */
/*
 * Testbench clock and reset source
 *   free running clock, reset held low for a few cycles
 */

`timescale 1ns/10ps

module clockGen #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // release shortly after an edge
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1 arstN = 1'b1;
    end

endmodule

/* tb/recoveryTb.sv */
/*
 * Testbench for the recovery controller
 *   stimulus table applied in a loop, reference model of
 *   recovered PC, flush range, walk latency and trap state,
 *   Galois LFSR for random fields, cycle-count timeout
 */

`timescale 1ns/10ps

module recoveryTb import recoveryPkg::*; ;

    localparam int numRows    = 11;
    localparam int driveDelay = 2;

    logic clk;
    logic arstN;
    logic excCommit;
    logic excRw;
    refetchType refetchTypeCommit;
    refetchType refetchTypeRw;
    logic [31:0] pcCommit;
    logic [31:0] pcRw;
    excCause causeCommit;
    logic [31:0] faultAddr;
    logic [3:0] excOpPtr;
    logic [3:0] detectedTailPtr;
    logic tvecWrite;
    logic [31:0] tvecData;
    logic fetchEnable;
    pipelinePhase phase;
    logic [31:0] fetchPc;
    logic [3:0] flushHeadPtr;
    logic [3:0] flushTailPtr;
    logic recoveryFromRw;
    logic unableToStartRecovery;
    logic [31:0] trapPc;
    excCause trapCause;
    logic [31:0] trapValue;

    // stimulus table, strobe bits are {stray, rw, commit}
    string       rowName [numRows];
    logic [2:0]  strobes [numRows];
    refetchType  typeCommitTab [numRows];
    refetchType  typeRwTab [numRows];
    logic [31:0] pcCommitTab [numRows];
    logic [31:0] pcRwTab [numRows];
    logic [3:0]  causeTab [numRows];
    logic [31:0] faultTab [numRows];
    logic [3:0]  opPtrTab [numRows];
    logic [3:0]  tailTab [numRows];
    logic        hasTvec [numRows];
    logic [31:0] tvecTab [numRows];

    logic [31:0] lfsrState;
    logic [31:0] modelTvec;
    logic [31:0] modelTrapPc;
    logic [3:0]  modelTrapCause;
    logic [31:0] modelTrapValue;
    int errorCount;
    int passCount;
    int failCount;
    int cycleCount;
    int timeoutLimit;

    clockGen #(.periodNs(20), .resetCycles(2)) u_clockGen (.clk(clk), .arstN(arstN));

    recoveryTop #(.alIndexBits(4)) u_recoveryTop (
        .clk(clk), .arstN(arstN),
        .excCommit(excCommit), .excRw(excRw),
        .refetchTypeCommit(refetchTypeCommit), .refetchTypeRw(refetchTypeRw),
        .pcCommit(pcCommit), .pcRw(pcRw),
        .causeCommit(causeCommit), .faultAddr(faultAddr),
        .excOpPtr(excOpPtr), .detectedTailPtr(detectedTailPtr),
        .tvecWrite(tvecWrite), .tvecData(tvecData), .fetchEnable(fetchEnable),
        .phase(phase), .fetchPc(fetchPc),
        .flushHeadPtr(flushHeadPtr), .flushTailPtr(flushTailPtr),
        .recoveryFromRw(recoveryFromRw), .unableToStartRecovery(unableToStartRecovery),
        .trapPc(trapPc), .trapCause(trapCause), .trapValue(trapValue)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        logic outBit;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            outBit = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) begin
                lfsrState = lfsrState ^ 32'h8020_0003;
            end
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    task automatic setRow(input int idx, input string name, input logic [2:0] strobeBits,
                          input refetchType tc, input refetchType tr,
                          input logic [31:0] pcc, input logic [31:0] pcr,
                          input logic [3:0] cause, input logic [31:0] fault,
                          input logic [3:0] opPtr, input logic [3:0] tail,
                          input logic newTvec, input logic [31:0] tvec);
        rowName[idx] = name;
        strobes[idx] = strobeBits;
        typeCommitTab[idx] = tc;
        typeRwTab[idx] = tr;
        pcCommitTab[idx] = pcc;
        pcRwTab[idx] = pcr;
        causeTab[idx] = cause;
        faultTab[idx] = fault;
        opPtrTab[idx] = opPtr;
        tailTab[idx] = tail;
        hasTvec[idx] = newTvec;
        tvecTab[idx] = tvec;
    endtask

    task automatic buildTable();
        setRow(0, "thisPcCommit", 3'b001, refetchThisPc, refetchThisPc,
               32'h0000_1000, 0, 4'h0, 0, 4'd3, 4'd7, 0, 0);
        setRow(1, "nextPcCommit", 3'b001, refetchNextPc, refetchThisPc,
               32'h0000_2004, 0, 4'h0, 0, 4'd5, 4'd6, 0, 0);
        setRow(2, "branchCommit", 3'b001, refetchBranchTarget, refetchThisPc,
               32'h0000_3ff0, 0, 4'h0, 0, 4'd2, 4'd10, 0, 0);
        setRow(3, "trapThisPc", 3'b001, refetchThisPcToCsr, refetchThisPc,
               32'h0000_4000, 0, 4'h2, 32'hdead_beef, 4'd1, 4'd4, 1, 32'h8000_0103);
        setRow(4, "trapNextPcRand", 3'b001, refetchNextPcToCsr, refetchThisPc,
               takeBits(30) << 2, 0, takeBits(4), takeBits(32), takeBits(4), takeBits(4), 0, 0);
        setRow(5, "wrapRange", 3'b001, refetchThisPc, refetchThisPc,
               32'h0000_5000, 0, 4'h0, 0, 4'd14, 4'd3, 0, 0);
        setRow(6, "rwOnly", 3'b010, refetchThisPc, refetchNextPc,
               0, 32'h0000_6008, 4'h0, 0, 4'd0, 4'd9, 0, 0);
        setRow(7, "bothStrobes", 3'b011, refetchThisPcToCsr, refetchNextPc,
               32'h0000_7000, 32'h0000_7700, 4'h5, 32'h0000_0abc, 4'd4, 4'd8, 1, 32'h0000_2222);
        setRow(8, "strobeInRecovery", 3'b101, refetchBranchTarget, refetchThisPc,
               32'h0000_8800, 0, 4'h0, 0, 4'd6, 4'd12, 0, 0);
        setRow(9, "rwRandom", 3'b010, refetchThisPc, refetchBranchTarget,
               0, takeBits(30) << 2, 4'h0, 0, takeBits(4), takeBits(4), 0, 0);
        setRow(10, "fullList", 3'b001, refetchNextPc, refetchThisPc,
               32'h0000_a000, 0, 4'h0, 0, 4'd7, 4'd7, 0, 0);
    endtask

    // flush head follows the winning refetch type
    function automatic logic [3:0] headOf(input int idx);
        refetchType kind;
        kind = strobes[idx][0] ? typeCommitTab[idx] : typeRwTab[idx];
        if (kind == refetchThisPc || kind == refetchThisPcToCsr) begin
            return opPtrTab[idx];
        end
        return opPtrTab[idx] + 4'd1;
    endfunction

    function automatic int walkLength(input int idx);
        logic [3:0] len;
        len = tailTab[idx] - headOf(idx);
        return int'(len);
    endfunction

    task automatic waitCycle();
        @(posedge clk);
        #driveDelay;
    endtask

    task automatic compareValue(input string testName, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s expected 0x%08h actual 0x%08h",
                     testName, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic runRow(input int idx);
        refetchType selType;
        logic [31:0] selPc;
        logic [31:0] expPc;
        int expLatency;
        int latency;
        int errorsBefore;
        errorsBefore = errorCount;
        selType = strobes[idx][0] ? typeCommitTab[idx] : typeRwTab[idx];
        selPc = strobes[idx][0] ? pcCommitTab[idx] : pcRwTab[idx];
        if (hasTvec[idx]) begin
            modelTvec = tvecTab[idx];
        end
        case (selType)
            refetchThisPcToCsr, refetchNextPcToCsr: expPc = {modelTvec[31:2], 2'b00};
            refetchNextPc: expPc = selPc + 32'd4;
            default: expPc = selPc;
        endcase
        if (selType == refetchThisPcToCsr || selType == refetchNextPcToCsr) begin
            modelTrapPc = pcCommitTab[idx];
            modelTrapCause = causeTab[idx];
            modelTrapValue = faultTab[idx];
        end
        expLatency = 2 + ((walkLength(idx) > 0) ? walkLength(idx) : 1);

        // vector written a cycle ahead of the trap
        if (hasTvec[idx]) begin
            tvecWrite = 1'b1;
            tvecData = tvecTab[idx];
            waitCycle();
            tvecWrite = 1'b0;
        end
        excCommit = strobes[idx][0];
        excRw = strobes[idx][1];
        refetchTypeCommit = typeCommitTab[idx];
        refetchTypeRw = typeRwTab[idx];
        pcCommit = pcCommitTab[idx];
        pcRw = pcRwTab[idx];
        causeCommit = causeTab[idx];
        faultAddr = faultTab[idx];
        excOpPtr = opPtrTab[idx];
        detectedTailPtr = tailTab[idx];
        waitCycle();
        latency = 1;
        excCommit = strobes[idx][2];
        excRw = 1'b0;
        // stray trap request that must be dropped
        if (strobes[idx][2]) begin
            refetchTypeCommit = refetchThisPcToCsr;
            pcCommit = takeBits(32);
            causeCommit = 4'hf;
            faultAddr = ~faultAddr;
            excOpPtr = ~excOpPtr;
            detectedTailPtr = ~detectedTailPtr;
        end
        compareValue(rowName[idx], "phase", 32'(phaseRecover0), 32'(phase));
        compareValue(rowName[idx], "flushHeadPtr", 32'(headOf(idx)), 32'(flushHeadPtr));
        compareValue(rowName[idx], "flushTailPtr", 32'(tailTab[idx]), 32'(flushTailPtr));
        compareValue(rowName[idx], "recoveryFromRw", 32'(strobes[idx][1]), 32'(recoveryFromRw));
        do begin
            compareValue(rowName[idx], "unableToStartRecovery", 1, 32'(unableToStartRecovery));
            waitCycle();
            latency++;
            excCommit = 1'b0;
            if (phase != phaseCommit) begin
                compareValue(rowName[idx], "fetchPc in recovery", expPc, fetchPc);
                compareValue(rowName[idx], "flushHeadPtr in recovery",
                             32'(headOf(idx)), 32'(flushHeadPtr));
                compareValue(rowName[idx], "flushTailPtr in recovery",
                             32'(tailTab[idx]), 32'(flushTailPtr));
            end
        end while (phase != phaseCommit);
        compareValue(rowName[idx], "latency", expLatency, latency);
        compareValue(rowName[idx], "fetchPc", expPc, fetchPc);
        compareValue(rowName[idx], "trapPc", modelTrapPc, trapPc);
        compareValue(rowName[idx], "trapCause", 32'(modelTrapCause), 32'(trapCause));
        compareValue(rowName[idx], "trapValue", modelTrapValue, trapValue);
        compareValue(rowName[idx], "unableToStartRecovery", 0, 32'(unableToStartRecovery));
        repeat (3) waitCycle();
        compareValue(rowName[idx], "fetchPc advance", expPc + 32'd12, fetchPc);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %-18s ok  latency %0d", rowName[idx], latency);
        end else begin
            failCount++;
            $display("test %-18s %0d mismatches", rowName[idx], errorCount - errorsBefore);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("timeout: no return to commit within %0d cycles", timeoutLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        excCommit = 1'b0;
        excRw = 1'b0;
        refetchTypeCommit = refetchThisPc;
        refetchTypeRw = refetchThisPc;
        pcCommit = '0;
        pcRw = '0;
        causeCommit = '0;
        faultAddr = '0;
        excOpPtr = '0;
        detectedTailPtr = '0;
        tvecWrite = 1'b0;
        tvecData = '0;
        fetchEnable = 1'b0;
        lfsrState = 32'h10eb;
        modelTvec = '0;
        modelTrapPc = '0;
        modelTrapCause = '0;
        modelTrapValue = '0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        cycleCount = 0;
        buildTable();
        timeoutLimit = 20;
        for (int i = 0; i < numRows; i++) begin
            timeoutLimit += 4 + walkLength(i) + 4;
        end
        wait (arstN === 1'b1);
        waitCycle();
        compareValue("reset", "phase", 32'(phaseCommit), 32'(phase));
        compareValue("reset", "fetchPc", 0, fetchPc);
        compareValue("reset", "trapPc", 0, trapPc);
        fetchEnable = 1'b1;
        for (int i = 0; i < numRows; i++) begin
            runRow(i);
        end
        $display("tests %0d  ok %0d  with mismatches %0d  check errors %0d",
                 numRows, passCount, failCount, errorCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
